//--- src/rv32_exec_cfg.svh
//################################################
// rv32 execute stage configuration
// data width, register count, bus address width
//################################################

`ifndef RV32_EXEC_CFG_SVH
`define RV32_EXEC_CFG_SVH

// data path and register width
`define EXEC_DATA_W 32

// architectural integer registers
`define EXEC_NREGS 32

// wishbone byte address width
`define EXEC_ADDR_W 32

`endif

//--- src/rv32_exec_pkg.sv
//################################################
// rv32 execute stage types
// words, opcodes, alu/load/branch codes and the
// fetch, control, wishbone and retire structs
//################################################

`include "rv32_exec_cfg.svh"

package rv32_exec_pkg;

  typedef logic [`EXEC_DATA_W-1:0]         word_t;
  typedef logic [`EXEC_ADDR_W-1:0]         addr_t;
  typedef logic [$clog2(`EXEC_NREGS)-1:0]  regaddr_t;
  // one enable bit per byte lane
  typedef logic [`EXEC_DATA_W/8-1:0]       sel_t;

  // base opcodes, all-ones is the halt encoding
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_AUIPC  = 7'b0010111,
    OP_JAL    = 7'b1101111,
    OP_JALR   = 7'b1100111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_HALT   = 7'b1111111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_t;

  // funct3 coding, stores use the same field
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_type_t;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_type_t;

  // operand and writeback selects
  typedef enum logic {A_RS1, A_PC} a_sel_t;
  typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_S, B_IMM_U} b_sel_t;
  typedef enum logic [1:0] {W_LOAD, W_PC4, W_IMM_U, W_ALU} w_sel_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
    word_t pc4;
    logic  prediction;
  } fetch_ex_t;

  typedef struct packed {
    regaddr_t     rs1;
    regaddr_t     rs2;
    regaddr_t     rd;
    alu_op_t      alu_op;
    a_sel_t       alu_a_sel;
    b_sel_t       alu_b_sel;
    w_sel_t       w_sel;
    logic         wen;
    logic         dren;
    logic         dwen;
    load_type_t   load_type;
    logic         branch;
    branch_type_t branch_type;
    logic         jump;
    // 1 selects jal, 0 jalr
    logic         j_sel;
    logic         halt;
    logic         illegal;
    word_t        imm_i;
    word_t        imm_s;
    word_t        imm_sb;
    word_t        imm_uj;
    word_t        imm_u;
  } ctrl_t;

  typedef struct packed {
    logic  cyc;
    logic  stb;
    logic  we;
    sel_t  sel;
    addr_t adr;
    word_t dat;
  } wb_m2s_t;

  typedef struct packed {
    word_t dat;
    logic  ack;
  } wb_s2m_t;

  typedef struct packed {
    logic     en;
    regaddr_t rd;
    word_t    data;
  } retire_t;

endpackage

//--- src/control_unit.sv
//################################################
// control unit
// decodes one rv32i instruction into the control
// struct with sign-extended immediates
//################################################

module control_unit (
  input  rv32_exec_pkg::word_t instr,
  output rv32_exec_pkg::ctrl_t ctrl
);

  import rv32_exec_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic       funct7_b5;

  assign opcode    = opcode_t'(instr[6:0]);
  assign funct3    = instr[14:12];
  // sub / sra select bit
  assign funct7_b5 = instr[30];

  // shared alu op decode for op and op-imm
  function automatic alu_op_t decode_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  decode_alu = alt ? ALU_SUB : ALU_ADD;
      3'b001:  decode_alu = ALU_SLL;
      3'b010:  decode_alu = ALU_SLT;
      3'b011:  decode_alu = ALU_SLTU;
      3'b100:  decode_alu = ALU_XOR;
      3'b101:  decode_alu = alt ? ALU_SRA : ALU_SRL;
      3'b110:  decode_alu = ALU_OR;
      default: decode_alu = ALU_AND;
    endcase
  endfunction

  always_comb begin
    // everything off by default
    ctrl = '0;
    ctrl.rs1 = instr[19:15];
    ctrl.rs2 = instr[24:20];
    ctrl.rd  = instr[11:7];
    ctrl.load_type   = load_type_t'(funct3);
    ctrl.branch_type = branch_type_t'(funct3);
    // immediates, all sign-extended from bit 31
    ctrl.imm_i  = {{20{instr[31]}}, instr[31:20]};
    ctrl.imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    ctrl.imm_sb = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_uj = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.imm_u  = {instr[31:12], 12'b0};
    case (opcode)
      OP_LUI: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = W_IMM_U;
      end
      OP_AUIPC: begin
        ctrl.wen       = 1'b1;
        ctrl.alu_a_sel = A_PC;
        ctrl.alu_b_sel = B_IMM_U;
        ctrl.w_sel     = W_ALU;
      end
      OP_JAL, OP_JALR: begin
        ctrl.wen   = 1'b1;
        ctrl.jump  = 1'b1;
        ctrl.j_sel = (opcode == OP_JAL);
        // link value
        ctrl.w_sel = W_PC4;
      end
      OP_BRANCH: begin
        // funct3 010 and 011 are unused
        ctrl.branch  = (funct3[2:1] != 2'b01);
        ctrl.illegal = (funct3[2:1] == 2'b01);
      end
      OP_LOAD: begin
        if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
          ctrl.wen       = 1'b1;
          ctrl.dren      = 1'b1;
          ctrl.alu_b_sel = B_IMM_I;
          ctrl.w_sel     = W_LOAD;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      OP_STORE: begin
        // sb, sh, sw only
        ctrl.dwen      = (funct3[2] == 1'b0) && (funct3 != 3'b011);
        ctrl.illegal   = !ctrl.dwen;
        ctrl.alu_b_sel = B_IMM_S;
      end
      OP_IMM: begin
        ctrl.wen       = 1'b1;
        ctrl.alu_b_sel = B_IMM_I;
        ctrl.w_sel     = W_ALU;
        // bit 30 only matters for srai
        ctrl.alu_op    = decode_alu(funct3, funct7_b5 && (funct3 == 3'b101));
      end
      OP_REG: begin
        ctrl.wen    = 1'b1;
        ctrl.w_sel  = W_ALU;
        ctrl.alu_op = decode_alu(funct3, funct7_b5);
      end
      OP_HALT: begin
        ctrl.halt    = (instr == '1);
        ctrl.illegal = (instr != '1);
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

//--- src/reg_file.sv
//################################################
// integer register file
// two async read ports, one sync write port,
// x0 reads as zero
//################################################

`include "rv32_exec_cfg.svh"

module reg_file (
  input  logic                    CLK,
  input  logic                    nRST,
  input  rv32_exec_pkg::regaddr_t rs1,
  input  rv32_exec_pkg::regaddr_t rs2,
  output rv32_exec_pkg::word_t    rs1_data,
  output rv32_exec_pkg::word_t    rs2_data,
  input  logic                    wen,
  input  rv32_exec_pkg::regaddr_t rd,
  input  rv32_exec_pkg::word_t    w_data
);

  import rv32_exec_pkg::*;

  word_t regs [`EXEC_NREGS];

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `EXEC_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != '0)) begin
      // x0 writes dropped here
      regs[rd] <= w_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

  // x0 storage must stay clear across every write
  a_x0_zero: assert property (@(posedge CLK) disable iff (!nRST) regs[0] == '0);

endmodule

//--- src/alu.sv
//################################################
// integer alu
// rv32i add, sub, shift, compare and logic ops
//################################################

module alu (
  input  rv32_exec_pkg::alu_op_t aluop,
  input  rv32_exec_pkg::word_t   port_a,
  input  rv32_exec_pkg::word_t   port_b,
  output rv32_exec_pkg::word_t   port_out
);

  import rv32_exec_pkg::*;

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;

  // only the low 5 bits shift
  assign shamt = port_b[4:0];
  assign lt_s  = $signed(port_a) < $signed(port_b);
  assign lt_u  = port_a < port_b;

  always_comb begin
    case (aluop)
      ALU_ADD:  port_out = port_a + port_b;
      ALU_SUB:  port_out = port_a - port_b;
      ALU_SLL:  port_out = port_a << shamt;
      // compares give 0 or 1
      ALU_SLT:  port_out = word_t'(lt_s);
      ALU_SLTU: port_out = word_t'(lt_u);
      ALU_XOR:  port_out = port_a ^ port_b;
      ALU_SRL:  port_out = port_a >> shamt;
      // arithmetic shift keeps the sign
      ALU_SRA:  port_out = word_t'($signed(port_a) >>> shamt);
      ALU_OR:   port_out = port_a | port_b;
      ALU_AND:  port_out = port_a & port_b;
      default:  port_out = '0;
    endcase
  end

endmodule

//--- src/branch_res.sv
//################################################
// branch resolver
// evaluates the branch condition and computes
// the branch target apart from the alu
//################################################

module branch_res (
  input  rv32_exec_pkg::word_t        rs1_data,
  input  rv32_exec_pkg::word_t        rs2_data,
  input  rv32_exec_pkg::word_t        pc,
  input  rv32_exec_pkg::word_t        imm_sb,
  input  rv32_exec_pkg::branch_type_t branch_type,
  output logic                        branch_taken,
  output rv32_exec_pkg::word_t        branch_addr
);

  import rv32_exec_pkg::*;

  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = rs1_data == rs2_data;
  assign lt_s = $signed(rs1_data) < $signed(rs2_data);
  assign lt_u = rs1_data < rs2_data;

  always_comb begin
    case (branch_type)
      BEQ:     branch_taken = eq;
      BNE:     branch_taken = !eq;
      BLT:     branch_taken = lt_s;
      BGE:     branch_taken = !lt_s;
      BLTU:    branch_taken = lt_u;
      BGEU:    branch_taken = !lt_u;
      default: branch_taken = 1'b0;
    endcase
  end

  // own adder so the alu stays free
  assign branch_addr = pc + imm_sb;

endmodule

//--- src/dmem_lsu.sv
//################################################
// data memory unit
// byte lanes, store replication, load extension,
// misalignment check, wishbone classic master
//################################################

module dmem_lsu (
  input  logic                      CLK,
  input  logic                      nRST,
  input  logic                      dren,
  input  logic                      dwen,
  input  rv32_exec_pkg::load_type_t load_type,
  input  rv32_exec_pkg::word_t      addr,
  input  rv32_exec_pkg::word_t      store_data,
  output rv32_exec_pkg::wb_m2s_t    wbm,
  input  rv32_exec_pkg::wb_s2m_t    wbs,
  output rv32_exec_pkg::word_t      load_data,
  output logic                      busy,
  output logic                      mal_addr
);

  import rv32_exec_pkg::*;

  sel_t    sel;
  logic    misaligned;
  word_t   lane;
  wb_m2s_t req_new;
  wb_m2s_t req_q;
  logic    pending;

  // lane enables from size and low address bits
  always_comb begin
    sel        = '0;
    misaligned = 1'b0;
    case (load_type)
      LB, LBU: sel = 4'b0001 << addr[1:0];
      LH, LHU: begin
        sel        = addr[1] ? 4'b1100 : 4'b0011;
        misaligned = addr[0];
      end
      LW: begin
        sel        = 4'b1111;
        misaligned = (addr[1:0] != 2'b00);
      end
      default: sel = '0;
    endcase
  end

  assign mal_addr = (dren | dwen) & misaligned;

  // request as presented this cycle
  always_comb begin
    req_new.cyc = (dren | dwen) & ~misaligned;
    req_new.stb = req_new.cyc;
    req_new.we  = dwen;
    req_new.sel = sel;
    // byte address, lanes picked by sel
    req_new.adr = addr;
    case (load_type)
      LB, LBU: req_new.dat = {4{store_data[7:0]}};
      LH, LHU: req_new.dat = {2{store_data[15:0]}};
      default: req_new.dat = store_data;
    endcase
  end

  // first cycle goes out combinationally
  // later cycles replay the held request
  assign wbm  = pending ? req_q : req_new;
  assign busy = wbm.cyc & ~wbs.ack;

  // clears on ack so each instruction gets one transfer
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pending <= 1'b0;
    end else begin
      pending <= busy;
    end
  end

  always_ff @(posedge CLK) begin
    if (busy && !pending) begin
      req_q <= req_new;
    end
  end

  // shift the addressed lane down to bit 0
  assign lane = wbs.dat >> {addr[1:0], 3'b000};

  always_comb begin
    case (load_type)
      LB:      load_data = word_t'($signed(lane[7:0]));
      LBU:     load_data = word_t'(lane[7:0]);
      LH:      load_data = word_t'($signed(lane[15:0]));
      LHU:     load_data = word_t'(lane[15:0]);
      default: load_data = wbs.dat;
    endcase
  end

  a_stb_cyc: assert property (@(posedge CLK) disable iff (!nRST) wbm.stb |-> wbm.cyc);

  a_sel_set: assert property (@(posedge CLK) disable iff (!nRST) wbm.stb |-> wbm.sel != '0);

  // request held unchanged until the slave acks
  a_adr_hold: assert property (@(posedge CLK) disable iff (!nRST)
    wbm.stb && !wbs.ack |=> wbm.stb && $stable(wbm.adr));

endmodule

//--- src/execute_stage.sv
//################################################
// rv32i execute stage
// decode, operands, alu, branch/jump resolution,
// load/store over wishbone and sticky halt
//################################################

module execute_stage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  rv32_exec_pkg::fetch_ex_t fex,
  output logic                     ex_stall,
  output rv32_exec_pkg::word_t     brj_addr,
  output logic                     mispredict,
  output rv32_exec_pkg::wb_m2s_t   wbm,
  input  rv32_exec_pkg::wb_s2m_t   wbs,
  output rv32_exec_pkg::retire_t   retire,
  output logic                     mal_l,
  output logic                     mal_s,
  output logic                     illegal_insn,
  output logic                     halt
);

  import rv32_exec_pkg::*;

  ctrl_t ctrl;
  word_t rs1_data, rs2_data;
  word_t port_a, port_b, alu_out;
  word_t jalr_sum, jump_addr, branch_addr;
  word_t load_data, w_data;
  logic  ex_valid, branch_taken, taken_or_jump;
  logic  dren, dwen, lsu_busy, mal_addr, rf_wen;

  // halted stage treats everything as a bubble
  assign ex_valid = fex.valid & ~halt;

  control_unit u_cu (.instr(fex.instr), .ctrl(ctrl));

  reg_file u_rf (
    .CLK(CLK), .nRST(nRST),
    .rs1(ctrl.rs1), .rs2(ctrl.rs2),
    .rs1_data(rs1_data), .rs2_data(rs2_data),
    .wen(rf_wen), .rd(ctrl.rd), .w_data(w_data)
  );

  // operand muxes
  assign port_a = (ctrl.alu_a_sel == A_PC) ? fex.pc : rs1_data;
  always_comb begin
    case (ctrl.alu_b_sel)
      B_IMM_I: port_b = ctrl.imm_i;
      B_IMM_S: port_b = ctrl.imm_s;
      B_IMM_U: port_b = ctrl.imm_u;
      default: port_b = rs2_data;
    endcase
  end

  alu u_alu (.aluop(ctrl.alu_op), .port_a(port_a), .port_b(port_b), .port_out(alu_out));

  branch_res u_br (
    .rs1_data(rs1_data), .rs2_data(rs2_data), .pc(fex.pc),
    .imm_sb(ctrl.imm_sb), .branch_type(ctrl.branch_type),
    .branch_taken(branch_taken), .branch_addr(branch_addr)
  );

  assign dren  = ex_valid & ctrl.dren;
  assign dwen  = ex_valid & ctrl.dwen;
  assign mal_l = dren & mal_addr;
  assign mal_s = dwen & mal_addr;

  dmem_lsu u_lsu (
    .CLK(CLK), .nRST(nRST), .dren(dren), .dwen(dwen),
    .load_type(ctrl.load_type), .addr(alu_out), .store_data(rs2_data),
    .wbm(wbm), .wbs(wbs), .load_data(load_data),
    .busy(lsu_busy), .mal_addr(mal_addr)
  );

  // jalr target has bit 0 cleared
  assign jalr_sum  = rs1_data + ctrl.imm_i;
  assign jump_addr = ctrl.j_sel ? (fex.pc + ctrl.imm_uj) : {jalr_sum[31:1], 1'b0};

  always_comb begin
    case (ctrl.w_sel)
      W_LOAD:  w_data = load_data;
      W_PC4:   w_data = fex.pc4;
      W_IMM_U: w_data = ctrl.imm_u;
      default: w_data = alu_out;
    endcase
  end

  // loads write in their ack cycle
  assign rf_wen      = ex_valid & ctrl.wen & ~lsu_busy & ~mal_l;
  assign retire.en   = rf_wen;
  assign retire.rd   = ctrl.rd;
  assign retire.data = w_data;

  // next pc and prediction check
  assign taken_or_jump = ctrl.jump | (ctrl.branch & branch_taken);
  assign brj_addr   = ctrl.jump ? jump_addr : (taken_or_jump ? branch_addr : fex.pc4);
  assign mispredict = ex_valid & (fex.prediction ^ taken_or_jump);

  assign ex_stall     = lsu_busy;
  assign illegal_insn = ex_valid & ctrl.illegal;

  // sticky until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (ex_valid && ctrl.halt) begin
      halt <= 1'b1;
    end
  end

  // once halted neither the bus nor the register file sees activity
  a_halt_quiet: assert property (@(posedge CLK) disable iff (!nRST)
    halt |-> !wbm.cyc && !retire.en);

endmodule

//--- verif/tb_execute.sv
//################################################
// execute stage testbench
// table driven stimulus, wishbone memory model
// with random ack delay, per-row result checks
//################################################

module tb_execute;

  import rv32_exec_pkg::*;

  localparam int PERIOD     = 40;
  localparam int RST_CYCLES = 10;
  localparam int MAX_DELAY  = 3;

  // flags: mal_l, mal_s, illegal, halt
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic        pred;
    logic        ren;
    logic [4:0]  rd;
    logic [31:0] rdata;
    logic [31:0] brj;
    logic        mp;
    logic        bus;
    logic        we;
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] dat;
    logic [3:0]  flags;
  } row_t;

  logic        CLK;
  logic        nRST;
  fetch_ex_t   fex;
  wb_s2m_t     wbs;
  wb_m2s_t     wbm;
  retire_t     retire;
  word_t       brj_addr;
  logic        ex_stall, mispredict, mal_l, mal_s, illegal_insn, halt;

  row_t        rows[$];
  logic [31:0] cur_pc;
  logic        table_done;
  int          err_count;
  integer      seed;
  logic [31:0] mem [64];
  logic [1:0]  wait_cnt;
  logic [1:0]  ack_delay;

  execute_stage dut0 (
    .CLK(CLK), .nRST(nRST), .fex(fex), .ex_stall(ex_stall),
    .brj_addr(brj_addr), .mispredict(mispredict), .wbm(wbm), .wbs(wbs),
    .retire(retire), .mal_l(mal_l), .mal_s(mal_s),
    .illegal_insn(illegal_insn), .halt(halt)
  );

  always #(PERIOD / 2) CLK = ~CLK;

  // instruction encoders, field layout per the rv32i spec
  function automatic logic [31:0] enc_i(logic [31:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    enc_i = {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3, logic [4:0] rd);
    enc_r = {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_s(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    enc_s = {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [31:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    enc_b = {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [31:0] imm, logic [4:0] rd);
    enc_j = {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  task automatic add_row(logic [31:0] instr, logic pred, logic ren, logic [4:0] rd,
                         logic [31:0] rdata, logic [31:0] brj, logic mp, logic bus,
                         logic we, logic [31:0] adr, logic [3:0] sel, logic [31:0] dat,
                         logic [3:0] flags);
    rows.push_back({instr, cur_pc, pred, ren, rd, rdata, brj, mp, bus, we, adr, sel, dat,
                    flags});
    cur_pc = cur_pc + 32'd4;
  endtask

  // plain register result, falls through to pc4
  task automatic alu_row(logic [31:0] instr, logic [4:0] rd, logic [31:0] data);
    add_row(instr, 1'b0, 1'b1, rd, data, cur_pc + 32'd4, 1'b0, 1'b0, 1'b0, '0, '0, '0, '0);
  endtask

  task automatic branch_row(logic [31:0] instr, logic pred, logic [31:0] brj, logic mp);
    add_row(instr, pred, 1'b0, '0, '0, brj, mp, 1'b0, 1'b0, '0, '0, '0, '0);
  endtask

  task automatic store_row(logic [31:0] instr, logic [31:0] adr, logic [3:0] sel,
                           logic [31:0] dat);
    add_row(instr, 1'b0, 1'b0, '0, '0, cur_pc + 32'd4, 1'b0, 1'b1, 1'b1, adr, sel, dat, '0);
  endtask

  task automatic load_row(logic [31:0] instr, logic [4:0] rd, logic [31:0] adr,
                          logic [3:0] sel, logic [31:0] data);
    add_row(instr, 1'b0, 1'b1, rd, data, cur_pc + 32'd4, 1'b0, 1'b1, 1'b0, adr, sel, '0, '0);
  endtask

  // no retire and no bus, only flags
  task automatic quiet_row(logic [31:0] instr, logic [3:0] flags);
    add_row(instr, 1'b0, 1'b0, '0, '0, cur_pc + 32'd4, 1'b0, 1'b0, 1'b0, '0, '0, '0, flags);
  endtask

  task automatic check(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at first error");
    end
  endtask

  task automatic build_table();
    cur_pc = 32'h100;
    alu_row(enc_i(5, 0, 3'b000, 1, 7'b0010011), 1, 32'd5);
    alu_row(enc_i(-3, 0, 3'b000, 2, 7'b0010011), 2, 32'hFFFFFFFD);
    alu_row(enc_r(7'h00, 2, 1, 3'b000, 3), 3, 32'd2);
    alu_row(enc_r(7'h20, 2, 1, 3'b000, 4), 4, 32'd8);
    alu_row({20'h12345, 5'd5, 7'b0110111}, 5, 32'h12345000);
    // auipc at 0x114
    alu_row({20'h00001, 5'd6, 7'b0010111}, 6, 32'h00001114);
    alu_row(enc_r(7'h00, 1, 1, 3'b001, 7), 7, 32'h000000A0);
    alu_row(enc_r(7'h20, 1, 2, 3'b101, 8), 8, 32'hFFFFFFFF);
    alu_row(enc_r(7'h00, 1, 2, 3'b101, 9), 9, 32'h07FFFFFF);
    alu_row(enc_r(7'h00, 1, 2, 3'b010, 10), 10, 32'd1);
    alu_row(enc_r(7'h00, 1, 2, 3'b011, 11), 11, 32'd0);
    alu_row(enc_r(7'h00, 2, 1, 3'b100, 12), 12, 32'hFFFFFFF8);
    alu_row(enc_r(7'h00, 2, 1, 3'b110, 13), 13, 32'hFFFFFFFD);
    alu_row(enc_r(7'h00, 2, 1, 3'b111, 14), 14, 32'd5);
    // x0 write reports data, then x0 still reads zero
    alu_row(enc_i(7, 1, 3'b000, 0, 7'b0010011), 0, 32'd12);
    alu_row(enc_r(7'h00, 1, 0, 3'b000, 15), 15, 32'd5);
    alu_row(enc_i(32'h401, 2, 3'b101, 16, 7'b0010011), 16, 32'hFFFFFFFE);
    cur_pc = 32'h200;
    branch_row(enc_b(16, 1, 1, 3'b000), 1'b1, 32'h210, 1'b0);
    branch_row(enc_b(16, 1, 1, 3'b001), 1'b1, 32'h208, 1'b1);
    branch_row(enc_b(-8, 1, 2, 3'b100), 1'b0, 32'h200, 1'b1);
    branch_row(enc_b(32, 1, 2, 3'b111), 1'b0, 32'h22C, 1'b1);
    branch_row(enc_b(32, 1, 2, 3'b110), 1'b0, 32'h214, 1'b0);
    branch_row(enc_b(8, 2, 1, 3'b101), 1'b1, 32'h21C, 1'b0);
    cur_pc = 32'h300;
    add_row(enc_j(32'h40, 17), 1'b0, 1'b1, 17, 32'h304, 32'h340, 1'b1, 1'b0, 1'b0, '0, '0, '0,
            '0);
    // 0x1114 + 3 with bit 0 dropped
    add_row(enc_i(3, 6, 3'b000, 18, 7'b1100111), 1'b1, 1'b1, 18, 32'h308, 32'h1116, 1'b0,
            1'b0, 1'b0, '0, '0, '0, '0);
    alu_row(enc_i(32'h40, 0, 3'b000, 19, 7'b0010011), 19, 32'h40);
    alu_row({20'hF1E2D, 5'd21, 7'b0110111}, 21, 32'hF1E2D000);
    alu_row(enc_i(32'h3C4, 21, 3'b000, 21, 7'b0010011), 21, 32'hF1E2D3C4);
    store_row(enc_s(1, 21, 19, 3'b000), 32'h41, 4'b0010, 32'hC4C4C4C4);
    store_row(enc_s(3, 21, 19, 3'b000), 32'h43, 4'b1000, 32'hC4C4C4C4);
    store_row(enc_s(4, 21, 19, 3'b001), 32'h44, 4'b0011, 32'hD3C4D3C4);
    store_row(enc_s(10, 21, 19, 3'b001), 32'h4A, 4'b1100, 32'hD3C4D3C4);
    store_row(enc_s(12, 21, 19, 3'b010), 32'h4C, 4'b1111, 32'hF1E2D3C4);
    store_row(enc_s(16, 21, 19, 3'b000), 32'h50, 4'b0001, 32'hC4C4C4C4);
    store_row(enc_s(18, 21, 19, 3'b000), 32'h52, 4'b0100, 32'hC4C4C4C4);
    // words 16..20 now C410C410, 9111D3C4, D3C41212, F1E2D3C4, 14C414C4
    load_row(enc_i(1, 19, 3'b000, 22, 7'b0000011), 22, 32'h41, 4'b0010, 32'hFFFFFFC4);
    load_row(enc_i(3, 19, 3'b100, 23, 7'b0000011), 23, 32'h43, 4'b1000, 32'h000000C4);
    load_row(enc_i(2, 19, 3'b100, 24, 7'b0000011), 24, 32'h42, 4'b0100, 32'h00000010);
    load_row(enc_i(4, 19, 3'b001, 25, 7'b0000011), 25, 32'h44, 4'b0011, 32'hFFFFD3C4);
    load_row(enc_i(6, 19, 3'b101, 26, 7'b0000011), 26, 32'h46, 4'b1100, 32'h00009111);
    load_row(enc_i(8, 19, 3'b101, 27, 7'b0000011), 27, 32'h48, 4'b0011, 32'h00001212);
    load_row(enc_i(12, 19, 3'b010, 28, 7'b0000011), 28, 32'h4C, 4'b1111, 32'hF1E2D3C4);
    load_row(enc_i(0, 19, 3'b010, 29, 7'b0000011), 29, 32'h40, 4'b1111, 32'hC410C410);
    load_row(enc_i(16, 19, 3'b010, 20, 7'b0000011), 20, 32'h50, 4'b1111, 32'h14C414C4);
    // untouched odd word 21
    load_row(enc_i(20, 19, 3'b010, 30, 7'b0000011), 30, 32'h54, 4'b1111, 32'h95151515);
    quiet_row(enc_i(1, 19, 3'b001, 22, 7'b0000011), 4'b1000);
    quiet_row(enc_i(2, 19, 3'b010, 22, 7'b0000011), 4'b1000);
    quiet_row(enc_s(1, 21, 19, 3'b010), 4'b0100);
    quiet_row(32'h0000000B, 4'b0010);
    alu_row(enc_r(7'h00, 0, 22, 3'b000, 31), 31, 32'hFFFFFFC4);
    quiet_row(32'hFFFFFFFF, 4'b0000);
    quiet_row(enc_i(1, 0, 3'b000, 1, 7'b0010011), 4'b0001);
    quiet_row(enc_s(0, 21, 19, 3'b010), 4'b0001);
  endtask

  // wishbone slave, ack after a random 0..3 cycle wait
  always_comb begin
    wbs.dat = mem[wbm.adr[7:2]];
    wbs.ack = wbm.cyc && wbm.stb && (wait_cnt >= ack_delay);
  end

  always @(posedge CLK or negedge nRST) begin : slave_seq
    logic [31:0] rnd;
    if (!nRST) begin
      wait_cnt  <= 2'd0;
      ack_delay <= 2'd0;
      // odd words get the top bit flipped
      for (int i = 0; i < 64; i++) begin
        mem[i] <= (i * 32'h01010101) ^ ((i % 2 == 1) ? 32'h80000000 : 32'h0);
      end
    end else if (wbm.cyc && wbm.stb) begin
      if (wbs.ack) begin
        if (wbm.we) begin
          for (int b = 0; b < 4; b++) begin
            if (wbm.sel[b]) begin
              mem[wbm.adr[7:2]][8*b +: 8] <= wbm.dat[8*b +: 8];
            end
          end
        end
        rnd = $random(seed);
        wait_cnt  <= 2'd0;
        ack_delay <= rnd[1:0];
      end else begin
        wait_cnt <= wait_cnt + 2'd1;
      end
    end
  end

  // watchdog sized from the table length
  initial begin : watchdog
    int limit;
    wait (table_done);
    limit = rows.size() * (4 + MAX_DELAY) * PERIOD + RST_CYCLES * PERIOD;
    #(limit);
    $display("timeout: stage did not finish the stimulus table in time");
    $display("FAIL: see errors above");
    $fatal(1, "watchdog expired");
  end

  initial begin : main
    row_t r;
    CLK        = 1'b0;
    nRST       <= 1'b0;
    fex        <= '0;
    seed       = 32'ha77d_fe0b;
    err_count  = 0;
    table_done = 1'b0;
    build_table();
    table_done = 1'b1;
    repeat (RST_CYCLES) @(posedge CLK);
    nRST <= 1'b1;
    // outputs quiet straight out of reset
    @(negedge CLK);
    check("wbm.cyc", 32'(wbm.cyc), 32'd0);
    check("wbm.stb", 32'(wbm.stb), 32'd0);
    check("retire.en", 32'(retire.en), 32'd0);
    check("ex_stall", 32'(ex_stall), 32'd0);
    check("halt", 32'(halt), 32'd0);
    check("mispredict", 32'(mispredict), 32'd0);
    foreach (rows[i]) begin
      r = rows[i];
      @(posedge CLK);
      fex.valid      <= 1'b1;
      fex.instr      <= r.instr;
      fex.pc         <= r.pc;
      fex.pc4        <= r.pc + 32'd4;
      fex.prediction <= r.pred;
      @(negedge CLK);
      check("brj_addr", brj_addr, r.brj);
      check("mispredict", 32'(mispredict), 32'(r.mp));
      check("mal_l", 32'(mal_l), 32'(r.flags[3]));
      check("mal_s", 32'(mal_s), 32'(r.flags[2]));
      check("illegal_insn", 32'(illegal_insn), 32'(r.flags[1]));
      check("halt", 32'(halt), 32'(r.flags[0]));
      check("wbm.cyc", 32'(wbm.cyc), 32'(r.bus));
      check("wbm.stb", 32'(wbm.stb), 32'(r.bus));
      if (r.bus) begin
        check("wbm.we", 32'(wbm.we), 32'(r.we));
        check("wbm.adr", wbm.adr, r.adr);
        check("wbm.sel", 32'(wbm.sel), 32'(r.sel));
        if (r.we) begin
          check("wbm.dat", wbm.dat, r.dat);
        end
      end else begin
        // no transfer, so the stage never holds fetch
        check("ex_stall", 32'(ex_stall), 32'd0);
      end
      // hold the row while the bus transfer runs
      while (ex_stall) begin
        check("retire.en", 32'(retire.en), 32'd0);
        @(negedge CLK);
      end
      check("retire.en", 32'(retire.en), 32'(r.ren));
      if (r.ren) begin
        check("retire.rd", 32'(retire.rd), 32'(r.rd));
        check("retire.data", retire.data, r.rdata);
      end
    end
    @(posedge CLK);
    if (err_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- project.f
+incdir+src
src/rv32_exec_pkg.sv
src/control_unit.sv
src/reg_file.sv
src/alu.sv
src/branch_res.sv
src/dmem_lsu.sv
src/execute_stage.sv
verif/tb_execute.sv

//--- run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f project.f \
  --top-module tb_execute \
  -Mdir obj_dir \
  -o sim_execute > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/sim_execute > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
exit 1
